// ==== hw/strobe_config.svh ====
`ifndef STROBE_CONFIG_SVH
`define STROBE_CONFIG_SVH

// Datapath widths
`define STROBE_PERIOD_W 16
`define STROBE_JITTER_W 8      // No more than 31
`define STROBE_COUNT_W  16

// Register map
`define STROBE_ADDR_PERIOD 2'd0
`define STROBE_ADDR_JITTER 2'd1
`define STROBE_ADDR_SEED   2'd2
`define STROBE_ADDR_CLEAR  2'd3

// PRNG state after reset
// Any value works as long as one word is non-zero
`define STROBE_PRNG_RESET_S0 32'h9e37_79b9
`define STROBE_PRNG_RESET_S1 32'h243f_6a88
`define STROBE_PRNG_RESET_S2 32'hb7e1_5162
`define STROBE_PRNG_RESET_S3 32'h1234_5678

`endif

// ==== hw/strobe_pkg.sv ====
`include "strobe_config.svh"

package strobe_pkg;

  // Period minus one or an interval length
  typedef logic [`STROBE_PERIOD_W-1:0] period_t;

  // Jitter probability level where 0 disables jitter
  typedef logic [`STROBE_JITTER_W-1:0] jitter_t;

  // xoshiro128+ state word or result
  typedef logic [31:0] prng_word_t;

  // Host register bank
  typedef logic [1:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Strobe event count
  typedef logic [`STROBE_COUNT_W-1:0] count_t;

endpackage

// ==== hw/strobe_ctrl_if.sv ====
// Settings from the register decode to the strobe generator
interface strobe_ctrl_if;

  import strobe_pkg::*;

  period_t    period_m1;   // Held level
  jitter_t    jitter;      // Held level
  logic [7:0] seed_byte;
  logic       seed_valid;  // One cycle per seed write

  modport decode (
    output period_m1,
    output jitter,
    output seed_byte,
    output seed_valid
  );

  modport execute (
    input  period_m1,
    input  jitter,
    input  seed_byte,
    input  seed_valid
  );

endinterface

// ==== hw/strobe_ctrl_decode.sv ====
`include "strobe_config.svh"

module strobe_ctrl_decode (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_wr_en,
  input  strobe_pkg::reg_addr_t i_wr_addr,
  input  strobe_pkg::reg_data_t i_wr_data,
  strobe_ctrl_if.decode         ctrl,
  output logic                  o_clear
);

  import strobe_pkg::*;

  period_t    period_q;
  jitter_t    jitter_q;
  logic [7:0] seed_byte_q;
  logic       seed_valid_q;
  logic       clear_q;

  logic wr_period;
  logic wr_jitter;
  logic wr_seed;
  logic wr_clear;

  // Address decode, independent of the clock gate
  assign wr_period = i_wr_en && (i_wr_addr == `STROBE_ADDR_PERIOD);
  assign wr_jitter = i_wr_en && (i_wr_addr == `STROBE_ADDR_JITTER);
  assign wr_seed   = i_wr_en && (i_wr_addr == `STROBE_ADDR_SEED);
  assign wr_clear  = i_wr_en && (i_wr_addr == `STROBE_ADDR_CLEAR);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      period_q <= '0;
      jitter_q <= '0;
    end else begin
      if (wr_period) begin
        period_q <= i_wr_data[`STROBE_PERIOD_W-1:0];
      end
      if (wr_jitter) begin
        jitter_q <= i_wr_data[`STROBE_JITTER_W-1:0];
      end
    end
  end

  // Command pulses
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      seed_valid_q <= 1'b0;
      clear_q      <= 1'b0;
    end else begin
      seed_valid_q <= wr_seed;
      clear_q      <= wr_clear;
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_seed) begin
      seed_byte_q <= i_wr_data[7:0];  // Low byte only
    end
  end

  assign ctrl.period_m1  = period_q;
  assign ctrl.jitter     = jitter_q;
  assign ctrl.seed_byte  = seed_byte_q;
  assign ctrl.seed_valid = seed_valid_q;
  assign o_clear         = clear_q;

endmodule

// ==== hw/prng_xoshiro128p.sv ====
`include "strobe_config.svh"

module prng_xoshiro128p (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cg,
  input  logic                   i_seed_valid,
  input  logic [7:0]             i_seed_byte,
  output strobe_pkg::prng_word_t o_result
);

  import strobe_pkg::*;

  prng_word_t s0_q;
  prng_word_t s1_q;
  prng_word_t s2_q;
  prng_word_t s3_q;

  prng_word_t s2_x;
  prng_word_t s3_x;
  prng_word_t s0_n;
  prng_word_t s1_n;
  prng_word_t s2_n;
  prng_word_t s3_n;

  logic [127:0] seed_shift;

  assign o_result = s0_q + s3_q;  // The plus scrambler

  // State transition
  assign s2_x = s2_q ^ s0_q;
  assign s3_x = s3_q ^ s1_q;
  assign s1_n = s1_q ^ s2_x;
  assign s0_n = s0_q ^ s3_x;
  assign s2_n = s2_x ^ (s1_q << 9);
  assign s3_n = {s3_x[20:0], s3_x[31:21]};  // Rotate left by 11

  // Byte enters at the bottom of s0, top byte of s3 drops out
  assign seed_shift = {s3_q[23:0], s2_q, s1_q, s0_q, i_seed_byte};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s0_q <= `STROBE_PRNG_RESET_S0;
      s1_q <= `STROBE_PRNG_RESET_S1;
      s2_q <= `STROBE_PRNG_RESET_S2;
      s3_q <= `STROBE_PRNG_RESET_S3;
    end else if (i_seed_valid) begin  // Seeding wins over stepping
      {s3_q, s2_q, s1_q, s0_q} <= seed_shift;
    end else if (i_cg) begin
      s0_q <= s0_n;
      s1_q <= s1_n;
      s2_q <= s2_n;
      s3_q <= s3_n;
    end
  end

  // An all-zero state would lock the generator up
  a_state_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (s0_q | s1_q | s2_q | s3_q) != '0);

endmodule

// ==== hw/strobe.sv ====
`include "strobe_config.svh"

// Clock-enable divider with random period jitter
module strobe (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cg,
  strobe_ctrl_if.execute         ctrl,
  output strobe_pkg::prng_word_t o_jitter_prng,
  output logic                   o_strobe
);

  import strobe_pkg::*;

  prng_word_t prng_result;
  jitter_t    jitter_draw;
  logic       jitter_fire;
  logic       extend_not_shorten;
  logic       jitter_extend;
  logic       jitter_shorten;
  period_t    count_q;
  period_t    count_d;
  logic       strobe_q;

  prng_xoshiro128p u_prng (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cg         (i_cg),
    .i_seed_valid (ctrl.seed_valid),
    .i_seed_byte  (ctrl.seed_byte),
    .o_result     (prng_result)
  );

  // Top bits of the result against the jitter level
  assign jitter_draw        = prng_result[32-`STROBE_JITTER_W +: `STROBE_JITTER_W];
  assign jitter_fire        = (jitter_draw < ctrl.jitter);
  assign extend_not_shorten = prng_result[31-`STROBE_JITTER_W];  // Bit just below the draw
  assign jitter_extend      = jitter_fire && extend_not_shorten;
  assign jitter_shorten     = jitter_fire && !extend_not_shorten;

  always_comb begin
    if (count_q == '0) begin
      count_d = ctrl.period_m1;  // Reload picks up new period
    end else if (jitter_shorten && (count_q != period_t'(1))) begin
      count_d = count_q - period_t'(2);
    end else begin
      count_d = count_q - period_t'(1);
    end
  end

  // Extend freezes the count for one cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (i_cg && !jitter_extend) begin
      count_q <= count_d;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      strobe_q <= 1'b0;
    end else if (i_cg) begin
      strobe_q <= (count_q == '0) && !jitter_extend;  // Pulse on reload
    end
  end

  assign o_jitter_prng = prng_result;
  assign o_strobe      = strobe_q;

  // Non-zero period keeps strobes apart across enabled cycles
  a_strobe_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_cg && $past(i_cg) && o_strobe && (ctrl.period_m1 != '0) && $stable(ctrl.period_m1))
    |=> !o_strobe);

endmodule

// ==== hw/strobe_event_stats.sv ====
module strobe_event_stats (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_cg,
  input  logic                i_strobe,
  input  logic                i_clear,
  output strobe_pkg::count_t  o_strobe_count,
  output strobe_pkg::period_t o_last_interval
);

  import strobe_pkg::*;

  count_t  count_q;
  period_t since_q;     // Enabled cycles after the last strobe
  period_t interval_q;
  logic    strobe_seen;

  assign strobe_seen = i_cg && i_strobe;  // A held strobe counts once

  // Clear overrides the increment
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count_q <= '0;
    end else if (i_clear) begin
      count_q <= '0;
    end else if (strobe_seen) begin
      count_q <= count_q + count_t'(1);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      since_q    <= '0;
      interval_q <= '0;
    end else if (strobe_seen) begin
      interval_q <= since_q + period_t'(1);  // Includes the strobe cycle
      since_q    <= '0;
    end else if (i_cg) begin
      since_q <= since_q + period_t'(1);
    end
  end

  assign o_strobe_count  = count_q;
  assign o_last_interval = interval_q;

endmodule

// ==== hw/strobe_top.sv ====
module strobe_top (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_cg,

  input  logic                   i_wr_en,
  input  strobe_pkg::reg_addr_t  i_wr_addr,
  input  strobe_pkg::reg_data_t  i_wr_data,

  output logic                   o_strobe,
  output strobe_pkg::prng_word_t o_jitter_prng,
  output strobe_pkg::count_t     o_strobe_count,
  output strobe_pkg::period_t    o_last_interval
);

  logic clear_pulse;   // Clear write, one cycle
  logic strobe_pulse;

  strobe_ctrl_if u_ctrl_if ();

  // Register writes to held settings and pulses
  strobe_ctrl_decode u_decode (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wr_en   (i_wr_en),
    .i_wr_addr (i_wr_addr),
    .i_wr_data (i_wr_data),
    .ctrl      (u_ctrl_if.decode),
    .o_clear   (clear_pulse)
  );

  strobe u_strobe (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cg          (i_cg),
    .ctrl          (u_ctrl_if.execute),
    .o_jitter_prng (o_jitter_prng),
    .o_strobe      (strobe_pulse)
  );

  // Count and interval statistics
  strobe_event_stats u_stats (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_cg            (i_cg),
    .i_strobe        (strobe_pulse),
    .i_clear         (clear_pulse),
    .o_strobe_count  (o_strobe_count),
    .o_last_interval (o_last_interval)
  );

  assign o_strobe = strobe_pulse;

endmodule

// ==== dv/strobe_tb.sv ====
`include "strobe_config.svh"

module strobe_tb;

  import strobe_pkg::*;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_cg;
  logic       i_wr_en;
  reg_addr_t  i_wr_addr;
  reg_data_t  i_wr_data;
  logic       o_strobe;
  prng_word_t o_jitter_prng;
  count_t     o_strobe_count;
  period_t    o_last_interval;

  logic [127:0] m_state;         // {s3, s2, s1, s0}
  prng_word_t   m_result;
  logic         seed_pend;       // Seed write seen last cycle
  logic [7:0]   seed_byte_pend;
  logic         clear_pend;
  count_t       tb_count;
  period_t      since;           // Enabled cycles after the last strobe
  int unsigned  moved_count = 0; // Jittered intervals
  logic         exact_mode;
  logic         jitter_mode;
  period_t      cur_period;

  logic [31:0]  rng;
  int unsigned  cycle_count = 0;
  int unsigned  cycle_limit = 0;
  int unsigned  error_count = 0;
  int unsigned  tests_run = 0;
  int unsigned  tests_failed = 0;
  int unsigned  errors_at_start = 0;

  int unsigned  exact_period [2];
  int unsigned  exact_count [2];
  int unsigned  seed_count;
  logic [7:0]   seed_bytes [8];
  int unsigned  jitter_period;
  int unsigned  jitter_count;
  int unsigned  gate_period;
  int unsigned  gate_offset;
  int unsigned  gate_len;
  int unsigned  gate_count;
  int unsigned  clear_count;

  strobe_top DUT (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_cg            (i_cg),
    .i_wr_en         (i_wr_en),
    .i_wr_addr       (i_wr_addr),
    .i_wr_data       (i_wr_data),
    .o_strobe        (o_strobe),
    .o_jitter_prng   (o_jitter_prng),
    .o_strobe_count  (o_strobe_count),
    .o_last_interval (o_last_interval)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int unsigned pick(input int unsigned lo, input int unsigned hi);
    return lo + (next_random() % (hi - lo + 1));
  endfunction

  // One xoshiro128+ step on {s3, s2, s1, s0}
  function automatic logic [127:0] xoshiro_next(input logic [127:0] st);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] t;
    a = st[31:0];
    b = st[63:32];
    c = st[95:64];
    d = st[127:96];
    t = b << 9;
    c = c ^ a;
    d = d ^ b;
    b = b ^ c;
    a = a ^ d;
    c = c ^ t;
    d = (d << 11) | (d >> 21);
    return {d, c, b, a};
  endfunction

  assign m_result = m_state[31:0] + m_state[127:96];

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      m_state        <= {`STROBE_PRNG_RESET_S3, `STROBE_PRNG_RESET_S2,
                         `STROBE_PRNG_RESET_S1, `STROBE_PRNG_RESET_S0};
      seed_pend      <= 1'b0;
      seed_byte_pend <= 8'h00;
      clear_pend     <= 1'b0;
      tb_count       <= '0;
      since          <= '0;
    end else begin
      if (seed_pend) begin
        m_state <= {m_state[119:0], seed_byte_pend};  // Byte shifted in at the bottom
      end else if (i_cg) begin
        m_state <= xoshiro_next(m_state);
      end
      seed_pend      <= i_wr_en && (i_wr_addr == `STROBE_ADDR_SEED);
      seed_byte_pend <= i_wr_data[7:0];
      clear_pend     <= i_wr_en && (i_wr_addr == `STROBE_ADDR_CLEAR);
      if (clear_pend) begin
        tb_count <= '0;
      end else if (i_cg && o_strobe) begin
        tb_count <= tb_count + count_t'(1);
      end
      if (i_cg) begin
        since <= o_strobe ? '0 : since + period_t'(1);
      end
    end
  end

  always @(posedge i_clk) begin
    if (jitter_mode && i_cg && o_strobe && since != cur_period) begin
      moved_count <= moved_count + 1;
    end
  end

  // Watchdog
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  a_prng_model: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_jitter_prng == m_result)
    else report_error($sformatf("PRNG result %h, expected %h",
                                $sampled(o_jitter_prng), $sampled(m_result)));

  a_prng_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!i_cg && !seed_pend) |=> $stable(o_jitter_prng))
    else report_error("PRNG moved while the clock gate was low");

  a_exact_gap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (exact_mode && i_cg && o_strobe) |-> (since == cur_period))
    else report_error("strobe gap differs from period plus one");

  a_exact_interval: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (exact_mode && i_cg && o_strobe) |=> (o_last_interval == cur_period + period_t'(1)))
    else report_error("last interval differs from period plus one");

  a_pulse_width: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (exact_mode && i_cg && o_strobe) |=> !o_strobe)
    else report_error("strobe pulse longer than one cycle");

  a_jitter_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (jitter_mode && i_cg && o_strobe) |->
      (since + period_t'(1) >= (cur_period >> 1) + period_t'(1)))
    else report_error("jittered interval below half the period plus one");

  a_gate_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_cg |-> !o_strobe)
    else report_error("strobe high while the clock gate was low");

  a_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_strobe_count == tb_count)
    else report_error("strobe count differs from strobes seen since clear");

  a_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    clear_pend |=> (o_strobe_count == '0))
    else report_error("strobe count not zero after clear");

  // Random test parameters and the cycle budget they need
  task automatic choose_parameters();
    int          i;
    int unsigned budget;
    budget = 600;
    for (i = 0; i < 2; i++) begin
      exact_period[i] = pick(3, 40);
      exact_count[i]  = pick(4, 10);
      budget += (exact_count[i] + 3) * 2 * (exact_period[i] + 1);
    end
    seed_count = pick(4, 8);
    for (i = 0; i < 8; i++) begin
      seed_bytes[i] = 8'(next_random());
    end
    jitter_period = pick(12, 40);
    jitter_count  = pick(20, 32);
    gate_period   = pick(4, 20);
    gate_offset   = pick(1, gate_period);
    gate_len      = pick(5, 20);
    gate_count    = pick(3, 6);
    clear_count   = pick(3, 8);
    budget += (jitter_count + 3) * 2 * (jitter_period + 1);
    budget += (gate_count + clear_count + 6) * 2 * (gate_period + 1) + gate_len;
    cycle_limit = budget + seed_count * 4;
  endtask

  task automatic start_test();
    errors_at_start = error_count;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, error_count - errors_at_start);
    end
  endtask

  // Starts at a falling edge, returns at the next one
  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    i_wr_en   = 1'b1;
    i_wr_addr = addr;
    i_wr_data = data;
    @(negedge i_clk);
    i_wr_en = 1'b0;
  endtask

  task automatic wait_strobes(input int unsigned n);
    repeat (n) begin
      do begin
        @(negedge i_clk);
      end while (!o_strobe);
    end
  endtask

  task automatic test_exact_period();
    int i;
    start_test();
    write_reg(`STROBE_ADDR_JITTER, '0);
    for (i = 0; i < 2; i++) begin
      write_reg(`STROBE_ADDR_PERIOD, reg_data_t'(exact_period[i]));
      cur_period = period_t'(exact_period[i]);
      wait_strobes(3);  // New period reaches the counter at a reload
      exact_mode = 1'b1;
      wait_strobes(exact_count[i]);
      exact_mode = 1'b0;
    end
    finish_test("exact period");
  endtask

  task automatic test_prng_seed();
    int i;
    start_test();
    for (i = 0; i < int'(seed_count); i++) begin
      if (i == 2) begin
        while (o_strobe) @(negedge i_clk);
        i_cg = 1'b0;  // Seed while stalled
      end
      write_reg(`STROBE_ADDR_SEED, reg_data_t'(seed_bytes[i]));
      if (i == 2) begin
        @(negedge i_clk);
        i_cg = 1'b1;
      end else if (i[0]) begin
        repeat (3) @(negedge i_clk);
      end
    end
    repeat (20) @(negedge i_clk);
    finish_test("PRNG sequence");
  endtask

  task automatic test_jitter();
    int unsigned moved_start;
    start_test();
    write_reg(`STROBE_ADDR_PERIOD, reg_data_t'(jitter_period));
    cur_period = period_t'(jitter_period);
    write_reg(`STROBE_ADDR_JITTER, reg_data_t'((1 << `STROBE_JITTER_W) - 1));
    wait_strobes(3);
    moved_start = moved_count;
    jitter_mode = 1'b1;
    wait_strobes(jitter_count);
    jitter_mode = 1'b0;
    assert (moved_count != moved_start)
      else report_error("no interval moved away from the period at maximum jitter");
    write_reg(`STROBE_ADDR_JITTER, '0);
    finish_test("jitter bounds");
  endtask

  task automatic test_clock_gate();
    start_test();
    write_reg(`STROBE_ADDR_PERIOD, reg_data_t'(gate_period));
    cur_period = period_t'(gate_period);
    wait_strobes(3);
    exact_mode = 1'b1;
    wait_strobes(1);
    repeat (gate_offset) @(negedge i_clk);
    while (o_strobe) @(negedge i_clk);
    i_cg = 1'b0;
    repeat (gate_len) @(negedge i_clk);
    i_cg = 1'b1;
    wait_strobes(gate_count);
    exact_mode = 1'b0;
    finish_test("clock gate");
  endtask

  task automatic test_count_clear();
    start_test();
    write_reg(`STROBE_ADDR_CLEAR, '0);
    wait_strobes(clear_count);
    @(negedge i_clk);  // Last strobe counted
    assert (o_strobe_count == count_t'(clear_count))
      else report_error($sformatf("strobe count %0d, expected %0d",
                                  o_strobe_count, clear_count));
    write_reg(`STROBE_ADDR_CLEAR, '0);
    @(negedge i_clk);
    assert (o_strobe_count == '0)
      else report_error($sformatf("strobe count %0d after clear", o_strobe_count));
    repeat (3) @(negedge i_clk);
    finish_test("count and clear");
  endtask

  initial begin
    i_rst_n     = 1'b0;
    i_cg        = 1'b1;
    i_wr_en     = 1'b0;
    i_wr_addr   = '0;
    i_wr_data   = '0;
    exact_mode  = 1'b0;
    jitter_mode = 1'b0;
    cur_period  = '0;
    rng         = 32'h6320_cbcc;
    choose_parameters();

    start_test();
    repeat (10) @(negedge i_clk);
    assert (!o_strobe && o_strobe_count == '0 && o_last_interval == '0)
      else report_error("outputs not cleared by reset");
    assert (o_jitter_prng == `STROBE_PRNG_RESET_S0 + `STROBE_PRNG_RESET_S3)
      else report_error("PRNG result differs from the reset state");
    i_rst_n = 1'b1;
    repeat (8) @(negedge i_clk);  // Period 0 strobes every cycle
    finish_test("reset state");

    test_exact_period();
    test_prng_seed();
    test_jitter();
    test_clock_gate();
    test_count_clear();

    $display("Tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/strobe_pkg.sv
hw/strobe_ctrl_if.sv
hw/strobe_ctrl_decode.sv
hw/prng_xoshiro128p.sv
hw/strobe.sv
hw/strobe_event_stats.sv
hw/strobe_top.sv
dv/strobe_tb.sv

// ==== Makefile ====
TOP := strobe_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f hw/*.sv hw/*.svh dv/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module strobe_top

clean:
	rm -rf obj_dir sim.log
